// ==== design/periph_pkg.sv ====
/*
 * Peripheral subsystem address map
 * Bus widths, select decode fields and per-block register offsets
 */
package periph_pkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 12;

  // Peripheral select field in paddr[11:8]
  localparam int SEL_LSB = 8;
  localparam int SEL_W   = 4;

  // Word offset field in paddr[7:2]
  localparam int OFS_LSB = 2;
  localparam int OFS_W   = 6;

  // Select values other than these are unmapped
  localparam logic [SEL_W-1:0] IRQ_SEL   = 4'd0;
  localparam logic [SEL_W-1:0] GPIO_SEL  = 4'd1;
  localparam logic [SEL_W-1:0] TIMER_SEL = 4'd2;

  // GPIO registers
  localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 6'd0;
  localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 6'd1;
  localparam logic [OFS_W-1:0] GPIO_OE_OFS  = 6'd2;
  localparam logic [OFS_W-1:0] GPIO_IE_OFS  = 6'd3;

  // Timer registers
  localparam logic [OFS_W-1:0] TMR_CTRL_OFS  = 6'd0;
  localparam logic [OFS_W-1:0] TMR_PRESC_OFS = 6'd1;
  localparam logic [OFS_W-1:0] TMR_COUNT_OFS = 6'd2;
  localparam logic [OFS_W-1:0] TMR_CMP_OFS   = 6'd3;

  // Interrupt controller registers
  localparam logic [OFS_W-1:0] IRQ_PEND_OFS  = 6'd0;
  localparam logic [OFS_W-1:0] IRQ_EN_OFS    = 6'd1;
  localparam logic [OFS_W-1:0] IRQ_CLAIM_OFS = 6'd2;

endpackage

// ==== design/apb_reg_bridge.sv ====
/*
 * APB slave bridge
 * Decodes select and offset into one-cycle register strobes, muxes read data and errors
 */
module apb_reg_bridge (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
  input  logic [periph_pkg::DATA_W-1:0] pwdata_i,
  output logic [periph_pkg::DATA_W-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output logic [periph_pkg::OFS_W-1:0]  reg_ofs_o,
  output logic [periph_pkg::DATA_W-1:0] reg_wdata_o,
  output logic                         irq_we_o,
  output logic                         irq_re_o,
  input  logic [periph_pkg::DATA_W-1:0] irq_rdata_i,
  input  logic                         irq_err_i,
  output logic                         gpio_we_o,
  output logic                         gpio_re_o,
  input  logic [periph_pkg::DATA_W-1:0] gpio_rdata_i,
  input  logic                         gpio_err_i,
  output logic                         tmr_we_o,
  output logic                         tmr_re_o,
  input  logic [periph_pkg::DATA_W-1:0] tmr_rdata_i,
  input  logic                         tmr_err_i
);

  import periph_pkg::*;

  logic [SEL_W-1:0]  sel;
  logic              acc_first;
  logic              done_q;
  logic              unmapped;
  logic [DATA_W-1:0] mux_rdata;
  logic              mux_err;
  logic [DATA_W-1:0] prdata_q;
  logic              pslverr_q;

  assign sel         = paddr_i[SEL_LSB +: SEL_W];
  assign reg_ofs_o   = paddr_i[OFS_LSB +: OFS_W];
  assign reg_wdata_o = pwdata_i;

  // Strobes only in the first access cycle since done_q marks the completing one
  assign acc_first = psel_i & penable_i & ~done_q;

  assign irq_we_o  = acc_first & pwrite_i & (sel == IRQ_SEL);
  assign irq_re_o  = acc_first & ~pwrite_i & (sel == IRQ_SEL);
  assign gpio_we_o = acc_first & pwrite_i & (sel == GPIO_SEL);
  assign gpio_re_o = acc_first & ~pwrite_i & (sel == GPIO_SEL);
  assign tmr_we_o  = acc_first & pwrite_i & (sel == TIMER_SEL);
  assign tmr_re_o  = acc_first & ~pwrite_i & (sel == TIMER_SEL);

  always_comb begin
    mux_rdata = '0;
    mux_err   = 1'b0;
    unmapped  = 1'b0;
    case (sel)
      IRQ_SEL: begin
        mux_rdata = irq_rdata_i;
        mux_err   = irq_err_i;
      end
      GPIO_SEL: begin
        mux_rdata = gpio_rdata_i;
        mux_err   = gpio_err_i;
      end
      TIMER_SEL: begin
        mux_rdata = tmr_rdata_i;
        mux_err   = tmr_err_i;
      end
      default: unmapped = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q    <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      done_q <= acc_first;
      if (acc_first) begin
        pslverr_q <= unmapped | mux_err;
      end
    end
  end

  // Read word captured with the strobe
  always_ff @(posedge clk_i) begin
    if (acc_first) begin
      prdata_q <= mux_rdata;
    end
  end

  assign pready_o  = done_q;
  assign pslverr_o = pslverr_q;
  assign prdata_o  = prdata_q;

  // Master must never raise penable outside a selected transfer
  a_penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i
  );

  a_one_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({irq_we_o, irq_re_o, gpio_we_o, gpio_re_o, tmr_we_o, tmr_re_o})
  );

endmodule

// ==== design/gpio_block.sv ====
/*
 * GPIO block
 * Output, output-enable and interrupt-enable registers, synchronized inputs, level interrupts
 */
module gpio_block #(
  parameter int GPIO_W = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         we_i,
  input  logic                         re_i,
  input  logic [periph_pkg::OFS_W-1:0]  ofs_i,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,
  output logic                         err_o,
  input  logic [GPIO_W-1:0]            gpio_i,
  output logic [GPIO_W-1:0]            gpio_o,
  output logic [GPIO_W-1:0]            gpio_oe_o,
  output logic [GPIO_W-1:0]            intr_o
);

  import periph_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] ie_q;
  logic [GPIO_W-1:0] meta_q;
  logic [GPIO_W-1:0] sync_q;
  logic [DATA_W-1:0] reg_word;
  logic              ofs_bad;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q  <= '0;
      oe_q   <= '0;
      ie_q   <= '0;
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      // Two-flop synchronizer on the pads
      meta_q <= gpio_i;
      sync_q <= meta_q;
      if (we_i) begin
        case (ofs_i)
          GPIO_OUT_OFS: out_q <= wdata_i[GPIO_W-1:0];
          GPIO_OE_OFS:  oe_q  <= wdata_i[GPIO_W-1:0];
          GPIO_IE_OFS:  ie_q  <= wdata_i[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Upper bits read as zero
  always_comb begin
    reg_word = '0;
    ofs_bad  = 1'b0;
    case (ofs_i)
      GPIO_IN_OFS:  reg_word[GPIO_W-1:0] = sync_q;
      GPIO_OUT_OFS: reg_word[GPIO_W-1:0] = out_q;
      GPIO_OE_OFS:  reg_word[GPIO_W-1:0] = oe_q;
      GPIO_IE_OFS:  reg_word[GPIO_W-1:0] = ie_q;
      default:      ofs_bad = 1'b1;
    endcase
  end

  assign rdata_o   = re_i ? reg_word : '0;
  assign err_o     = (we_i | re_i) & ofs_bad;
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = sync_q & ie_q;

endmodule

// ==== design/timer_block.sv ====
/*
 * Prescaled timer
 * Up-counter advancing every PRESC+1 cycles with a compare level interrupt
 */
module timer_block (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         we_i,
  input  logic                         re_i,
  input  logic [periph_pkg::OFS_W-1:0]  ofs_i,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,
  output logic                         err_o,
  output logic                         intr_o
);

  import periph_pkg::*;

  logic              en_q;
  logic [DATA_W-1:0] presc_q;
  logic [DATA_W-1:0] tick_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;
  logic              wr_ctrl;
  logic              wr_presc;
  logic              wr_count;
  logic              wr_cmp;
  logic              tick;
  logic [DATA_W-1:0] reg_word;
  logic              ofs_bad;

  assign wr_ctrl  = we_i & (ofs_i == TMR_CTRL_OFS);
  assign wr_presc = we_i & (ofs_i == TMR_PRESC_OFS);
  assign wr_count = we_i & (ofs_i == TMR_COUNT_OFS);
  assign wr_cmp   = we_i & (ofs_i == TMR_CMP_OFS);

  // End of a prescaler period
  assign tick = en_q & (tick_q == presc_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      presc_q <= '0;
      tick_q  <= '0;
      count_q <= '0;
      cmp_q   <= '0;
    end else begin
      if (wr_ctrl) begin
        en_q <= wdata_i[0];
      end
      if (wr_presc) begin
        presc_q <= wdata_i;
      end
      if (wr_cmp) begin
        cmp_q <= wdata_i;
      end
      // New prescale restarts the period
      if (wr_presc || !en_q || tick) begin
        tick_q <= '0;
      end else begin
        tick_q <= tick_q + 1'b1;
      end
      if (wr_count) begin
        count_q <= wdata_i;
      end else if (tick) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    reg_word = '0;
    ofs_bad  = 1'b0;
    case (ofs_i)
      TMR_CTRL_OFS:  reg_word[0] = en_q;
      TMR_PRESC_OFS: reg_word = presc_q;
      TMR_COUNT_OFS: reg_word = count_q;
      TMR_CMP_OFS:   reg_word = cmp_q;
      default:       ofs_bad = 1'b1;
    endcase
  end

  assign rdata_o = re_i ? reg_word : '0;
  assign err_o   = (we_i | re_i) & ofs_bad;
  assign intr_o  = en_q & (count_q >= cmp_q);

  a_tick_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) tick_q <= presc_q
  );

endmodule

// ==== design/irq_ctrl.sv ====
/*
 * Simplified platform interrupt controller
 * Pending, enable and in-service per source with claim/complete, lowest id first
 */
module irq_ctrl #(
  parameter int NUM_SRC = 14
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         we_i,
  input  logic                         re_i,
  input  logic [periph_pkg::OFS_W-1:0]  ofs_i,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,
  output logic                         err_o,
  input  logic [NUM_SRC-1:0]           src_i,
  output logic                         irq_o
);

  import periph_pkg::*;

  localparam int ID_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

  logic [NUM_SRC-1:0] pend_q;
  logic [NUM_SRC-1:0] en_q;
  logic [NUM_SRC-1:0] insvc_q;
  logic               irq_q;
  logic [NUM_SRC-1:0] active;
  logic [NUM_SRC-1:0] src_set;
  logic [ID_W-1:0]    claim_id;
  logic [ID_W-1:0]    cmp_id;
  logic               claim_fire;
  logic               complete_fire;
  logic               wr_en;
  logic [DATA_W-1:0]  reg_word;
  logic               ofs_bad;

  assign active  = pend_q & en_q;
  // Gateway allows one outstanding request per source
  assign src_set = src_i & ~pend_q & ~insvc_q;

  // Lowest enabled pending id wins and 0 means none
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = ID_W'(i);
      end
    end
  end

  assign cmp_id        = wdata_i[ID_W-1:0];
  assign claim_fire    = re_i & (ofs_i == IRQ_CLAIM_OFS) & (claim_id != '0);
  assign complete_fire = we_i & (ofs_i == IRQ_CLAIM_OFS) & (wdata_i < DATA_W'(NUM_SRC));
  assign wr_en         = we_i & (ofs_i == IRQ_EN_OFS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q  <= '0;
      en_q    <= '0;
      insvc_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      pend_q <= pend_q | src_set;
      if (claim_fire) begin
        pend_q[claim_id]  <= 1'b0;
        insvc_q[claim_id] <= 1'b1;
      end
      if (complete_fire) begin
        insvc_q[cmp_id] <= 1'b0;
      end
      if (wr_en) begin
        en_q <= {wdata_i[NUM_SRC-1:1], 1'b0};
      end
      irq_q <= |active;
    end
  end

  always_comb begin
    reg_word = '0;
    ofs_bad  = 1'b0;
    case (ofs_i)
      IRQ_PEND_OFS:  reg_word[NUM_SRC-1:0] = pend_q;
      IRQ_EN_OFS:    reg_word[NUM_SRC-1:0] = en_q;
      IRQ_CLAIM_OFS: reg_word[ID_W-1:0] = claim_id;
      default:       ofs_bad = 1'b1;
    endcase
  end

  assign rdata_o = re_i ? reg_word : '0;
  assign err_o   = (we_i | re_i) & ofs_bad;
  assign irq_o   = irq_q;

  // A claimed id stays out of pending until completed
  a_pend_excl_insvc: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (pend_q & insvc_q) == '0
  );

endmodule

// ==== design/periph_subsystem.sv ====
/*
 * Peripheral subsystem top
 * APB bridge with GPIO, timer and interrupt controller behind it
 */
module periph_subsystem #(
  parameter int GPIO_W      = 8,
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
  input  logic [periph_pkg::DATA_W-1:0] pwdata_i,
  output logic [periph_pkg::DATA_W-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  logic [GPIO_W-1:0]            gpio_i,
  output logic [GPIO_W-1:0]            gpio_o,
  output logic [GPIO_W-1:0]            gpio_oe_o,
  input  logic [NUM_EXT_IRQ-1:0]       ext_irq_i,
  output logic                         irq_o
);

  import periph_pkg::*;

  localparam int NUM_SRC = 1 + GPIO_W + 1 + NUM_EXT_IRQ;

  logic [OFS_W-1:0]   reg_ofs;
  logic [DATA_W-1:0]  reg_wdata;
  logic               irq_we, irq_re, irq_err;
  logic               gpio_we, gpio_re, gpio_err;
  logic               tmr_we, tmr_re, tmr_err;
  logic [DATA_W-1:0]  irq_rdata, gpio_rdata, tmr_rdata;
  logic [GPIO_W-1:0]  gpio_intr;
  logic               tmr_intr;
  logic [NUM_SRC-1:0] intr_vec;

  // Id 0 is reserved and followed by pins, timer and external lines
  assign intr_vec = {ext_irq_i, tmr_intr, gpio_intr, 1'b0};

  apb_reg_bridge u_bridge (
    .clk_i,
    .rst_n_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .reg_ofs_o    (reg_ofs),
    .reg_wdata_o  (reg_wdata),
    .irq_we_o     (irq_we),
    .irq_re_o     (irq_re),
    .irq_rdata_i  (irq_rdata),
    .irq_err_i    (irq_err),
    .gpio_we_o    (gpio_we),
    .gpio_re_o    (gpio_re),
    .gpio_rdata_i (gpio_rdata),
    .gpio_err_i   (gpio_err),
    .tmr_we_o     (tmr_we),
    .tmr_re_o     (tmr_re),
    .tmr_rdata_i  (tmr_rdata),
    .tmr_err_i    (tmr_err)
  );

  gpio_block #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .clk_i,
    .rst_n_i,
    .we_i      (gpio_we),
    .re_i      (gpio_re),
    .ofs_i     (reg_ofs),
    .wdata_i   (reg_wdata),
    .rdata_o   (gpio_rdata),
    .err_o     (gpio_err),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o    (gpio_intr)
  );

  timer_block u_timer (
    .clk_i,
    .rst_n_i,
    .we_i    (tmr_we),
    .re_i    (tmr_re),
    .ofs_i   (reg_ofs),
    .wdata_i (reg_wdata),
    .rdata_o (tmr_rdata),
    .err_o   (tmr_err),
    .intr_o  (tmr_intr)
  );

  irq_ctrl #(
    .NUM_SRC (NUM_SRC)
  ) u_irq (
    .clk_i,
    .rst_n_i,
    .we_i    (irq_we),
    .re_i    (irq_re),
    .ofs_i   (reg_ofs),
    .wdata_i (reg_wdata),
    .rdata_o (irq_rdata),
    .err_o   (irq_err),
    .src_i   (intr_vec),
    .irq_o
  );

endmodule

// ==== test/periph_tb.sv ====
/*
 * Peripheral subsystem testbench
 * Directed APB tests of the GPIO, timer and interrupt controller
 */
module periph_tb;

  import periph_pkg::*;

  localparam int GPIO_W         = 8;
  localparam int NUM_EXT_IRQ    = 4;
  localparam int TMR_ID         = GPIO_W + 1;
  localparam int EXT_ID0        = GPIO_W + 2;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam logic [DATA_W-1:0] PIN_MASK = (DATA_W'(1) << GPIO_W) - 1;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [ADDR_W-1:0]      paddr;
  logic [DATA_W-1:0]      pwdata;
  logic [DATA_W-1:0]      prdata;
  logic                   pready;
  logic                   pslverr;
  logic [GPIO_W-1:0]      gpio_in;
  logic [GPIO_W-1:0]      gpio_out;
  logic [GPIO_W-1:0]      gpio_oe;
  logic [NUM_EXT_IRQ-1:0] ext_irq;
  logic                   irq;

  logic [31:0] lfsr_state = 32'hcb37_0820;
  int          error_cnt  = 0;
  int          check_cnt  = 0;
  int          cycle_cnt  = 0;

  periph_subsystem #(
    .GPIO_W      (GPIO_W),
    .NUM_EXT_IRQ (NUM_EXT_IRQ)
  ) DUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .ext_irq_i (ext_irq),
    .irq_o     (irq)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Right-shift Galois form stepped once per bit
  function automatic logic lfsr_step();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [DATA_W-1:0] rand_bits(input int nbits);
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[DATA_W-2:0], lfsr_step()};
    end
    return w;
  endfunction

  function automatic logic [ADDR_W-1:0] addr_of(input logic [SEL_W-1:0] sel,
                                                input logic [OFS_W-1:0] ofs);
    return {sel, ofs, 2'b00};
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_cnt++;
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    check_cnt++;
    if (got !== exp) begin
      report_error($sformatf("%s: got 0x%08h, expected 0x%08h", what, got, exp));
    end
  endtask

  task automatic check_pins(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp,
                            input string what);
    check_cnt++;
    if (got !== exp) begin
      report_error($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      report_error($sformatf("%s: pslverr %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      report_error($sformatf("%s: irq_o %b, expected %b", what, got, exp));
    end
  endtask

  // Setup and access until pready, then hold through the completing edge
  task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    logic [DATA_W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_reg(input logic [SEL_W-1:0] sel, input logic [OFS_W-1:0] ofs,
                           input logic [DATA_W-1:0] data);
    logic err;
    apb_write(addr_of(sel, ofs), data, err);
    check_err(err, 1'b0, $sformatf("write sel %0d ofs %0d", sel, ofs));
  endtask

  task automatic read_expect(input logic [SEL_W-1:0] sel, input logic [OFS_W-1:0] ofs,
                             input logic [DATA_W-1:0] exp, input string what);
    logic [DATA_W-1:0] data;
    logic              err;
    apb_read(addr_of(sel, ofs), data, err);
    check_err(err, 1'b0, what);
    check_data(data, exp, what);
  endtask

  // Polls irq_o on falling edges
  task automatic wait_irq(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level) begin
      $display("irq_o did not reach %0b within %0d cycles (time %0t)", level, max_cycles, $time);
      error_cnt++;
    end
  endtask

  task automatic reset_and_decode();
    logic [DATA_W-1:0] data;
    logic              err;
    read_expect(GPIO_SEL, GPIO_OUT_OFS, '0, "GPIO_OUT after reset");
    read_expect(GPIO_SEL, GPIO_OE_OFS, '0, "GPIO_OE after reset");
    read_expect(IRQ_SEL, IRQ_EN_OFS, '0, "IRQ_EN after reset");
    read_expect(TIMER_SEL, TMR_CTRL_OFS, '0, "TMR_CTRL after reset");
    check_pins(gpio_out, '0, "gpio_o after reset");
    check_irq(irq, 1'b0, "irq_o after reset");
    apb_read(addr_of(4'd5, 6'd0), data, err);
    check_err(err, 1'b1, "read of unmapped select");
    check_data(data, '0, "read data of unmapped select");
    apb_write(addr_of(4'd5, 6'd0), 32'hdead_beef, err);
    check_err(err, 1'b1, "write to unmapped select");
    apb_read(addr_of(GPIO_SEL, 6'd9), data, err);
    check_err(err, 1'b1, "read of unknown GPIO offset");
    check_data(data, '0, "read data of unknown GPIO offset");
  endtask

  task automatic gpio_outputs();
    logic [DATA_W-1:0] out_val;
    logic [DATA_W-1:0] oe_val;
    for (int i = 0; i < 4; i++) begin
      out_val = rand_bits(DATA_W);
      oe_val  = rand_bits(DATA_W);
      write_reg(GPIO_SEL, GPIO_OUT_OFS, out_val);
      write_reg(GPIO_SEL, GPIO_OE_OFS, oe_val);
      read_expect(GPIO_SEL, GPIO_OUT_OFS, out_val & PIN_MASK, "GPIO_OUT readback");
      read_expect(GPIO_SEL, GPIO_OE_OFS, oe_val & PIN_MASK, "GPIO_OE readback");
      check_pins(gpio_out, out_val[GPIO_W-1:0], "gpio_o");
      check_pins(gpio_oe, oe_val[GPIO_W-1:0], "gpio_oe_o");
    end
    write_reg(GPIO_SEL, GPIO_OUT_OFS, '0);
    write_reg(GPIO_SEL, GPIO_OE_OFS, '0);
  endtask

  task automatic gpio_input_irq();
    logic [GPIO_W-1:0] pat;
    int                pin;
    pat = GPIO_W'(rand_bits(GPIO_W));
    @(negedge clk);
    gpio_in = pat;
    repeat (3) @(negedge clk);
    read_expect(GPIO_SEL, GPIO_IN_OFS, DATA_W'(pat), "GPIO_IN after synchronizer");
    gpio_in = '0;
    pin = int'(rand_bits(3));
    write_reg(GPIO_SEL, GPIO_IE_OFS, DATA_W'(1) << pin);
    write_reg(IRQ_SEL, IRQ_EN_OFS, DATA_W'(1) << (pin + 1));
    @(negedge clk);
    gpio_in[pin] = 1'b1;
    wait_irq(1'b1, 12);
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(pin + 1), "claim of GPIO pin id");
    gpio_in[pin] = 1'b0;
    repeat (3) @(negedge clk);
    write_reg(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(pin + 1));
    repeat (2) @(negedge clk);
    check_irq(irq, 1'b0, "irq_o after GPIO complete");
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, '0, "claim with nothing pending");
    write_reg(GPIO_SEL, GPIO_IE_OFS, '0);
    write_reg(IRQ_SEL, IRQ_EN_OFS, '0);
  endtask

  task automatic timer_compare();
    logic [DATA_W-1:0] data;
    logic              err;
    write_reg(IRQ_SEL, IRQ_EN_OFS, DATA_W'(1) << TMR_ID);
    write_reg(TIMER_SEL, TMR_PRESC_OFS, 32'd3);
    write_reg(TIMER_SEL, TMR_CMP_OFS, 32'd20);
    write_reg(TIMER_SEL, TMR_COUNT_OFS, '0);
    write_reg(TIMER_SEL, TMR_CTRL_OFS, 32'd1);
    // Twenty counts of four cycles each with margin
    wait_irq(1'b1, 200);
    apb_read(addr_of(TIMER_SEL, TMR_COUNT_OFS), data, err);
    check_err(err, 1'b0, "read of timer COUNT");
    check_cnt++;
    if (data < 32'd20) begin
      report_error($sformatf("timer COUNT %0d below compare value 20", data));
    end
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(TMR_ID), "claim of timer id");
    write_reg(TIMER_SEL, TMR_COUNT_OFS, '0);
    write_reg(TIMER_SEL, TMR_CTRL_OFS, '0);
    write_reg(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(TMR_ID));
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, '0, "claim after timer complete");
    check_irq(irq, 1'b0, "irq_o after timer complete");
    write_reg(IRQ_SEL, IRQ_EN_OFS, '0);
  endtask

  task automatic claim_ordering();
    int                pin;
    int                gpio_id;
    logic [DATA_W-1:0] ids;
    pin     = int'(rand_bits(3));
    gpio_id = pin + 1;
    ids     = (DATA_W'(1) << gpio_id) | (DATA_W'(1) << EXT_ID0) | (DATA_W'(1) << (EXT_ID0 + 2));
    write_reg(GPIO_SEL, GPIO_IE_OFS, DATA_W'(1) << pin);
    write_reg(IRQ_SEL, IRQ_EN_OFS, ids);
    @(negedge clk);
    ext_irq[0]   = 1'b1;
    ext_irq[2]   = 1'b1;
    gpio_in[pin] = 1'b1;
    repeat (4) @(negedge clk);
    check_irq(irq, 1'b1, "irq_o with three sources raised");
    read_expect(IRQ_SEL, IRQ_PEND_OFS, ids, "PENDING with three sources");
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(gpio_id), "first claim");
    read_expect(IRQ_SEL, IRQ_PEND_OFS, ids & ~(DATA_W'(1) << gpio_id), "PENDING after claim");
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(EXT_ID0), "second claim");
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(EXT_ID0 + 2), "third claim");
    read_expect(IRQ_SEL, IRQ_PEND_OFS, '0, "PENDING with all ids in service");
    // Source still high, so the id pends again once completed
    write_reg(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(gpio_id));
    read_expect(IRQ_SEL, IRQ_PEND_OFS, DATA_W'(1) << gpio_id, "PENDING after complete");
    @(negedge clk);
    ext_irq = '0;
    gpio_in = '0;
    repeat (3) @(negedge clk);
    write_reg(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(EXT_ID0));
    write_reg(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(EXT_ID0 + 2));
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(gpio_id), "claim of re-pended GPIO id");
    write_reg(IRQ_SEL, IRQ_CLAIM_OFS, DATA_W'(gpio_id));
    read_expect(IRQ_SEL, IRQ_CLAIM_OFS, '0, "claim after all completes");
    wait_irq(1'b0, 4);
    write_reg(GPIO_SEL, GPIO_IE_OFS, '0);
    write_reg(IRQ_SEL, IRQ_EN_OFS, '0);
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    gpio_in = '0;
    ext_irq = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    reset_and_decode();
    gpio_outputs();
    gpio_input_irq();
    timer_compare();
    claim_ordering();
    $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/periph_pkg.sv
design/apb_reg_bridge.sv
design/gpio_block.sv
design/timer_block.sv
design/irq_ctrl.sv
design/periph_subsystem.sv
test/periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module periph_tb \
  -f files.f \
  --Mdir obj_dir \
  -o periph_sim

# A crash or assertion stop shows up as a missing pass line
sim_out="$(./obj_dir/periph_sim 2>&1)" || true
echo "$sim_out"

if grep -q "^ALL TESTS PASSED$" <<< "$sim_out"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
